//--- src/fetch_pkg.sv
// shared widths and encodings for the fetch frontend
// addresses and instruction words are fixed at 32 bit
// only uncompressed, word aligned instructions are fetched

package fetch_pkg;

  // ------------------------------------------------------------
  // widths
  // ------------------------------------------------------------

  // width of a fetch address
  localparam int unsigned AddrWidth = 32;

  // width of one instruction word
  localparam int unsigned InstrWidth = 32;

  // ------------------------------------------------------------
  // vector types
  // ------------------------------------------------------------

  // instruction address
  typedef logic [AddrWidth-1:0] addr_t;

  // raw instruction word as returned by memory
  typedef logic [InstrWidth-1:0] instr_t;

  // control-flow kind of a predecoded word
  typedef logic [1:0] cf_t;

  // ------------------------------------------------------------
  // control-flow kind codes
  // ------------------------------------------------------------

  // plain instruction, no change of flow
  localparam cf_t CF_NONE = 2'd0;

  // conditional branch, B-type immediate
  localparam cf_t CF_BRANCH = 2'd1;

  // jal, J-type immediate, always taken
  localparam cf_t CF_JUMP = 2'd2;

  // jalr, target depends on a register and is never predicted
  localparam cf_t CF_JUMPR = 2'd3;

  // byte step between two sequential instructions
  localparam addr_t InstrBytes = 32'd4;

endpackage

//--- src/fetch_pc_gen.sv
// next-PC register of the fetch frontend
// boot_addr_i is sampled on the first cycle after reset release
// redirects are single-cycle pulses, exception > eret > mispredict

`timescale 1ns/1ps

module fetch_pc_gen (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  fetch_pkg::addr_t boot_addr_i,
  input  logic             ex_valid_i,
  input  fetch_pkg::addr_t trap_vector_i,
  input  logic             eret_i,
  input  fetch_pkg::addr_t epc_i,
  input  logic             mispredict_i,
  input  fetch_pkg::addr_t mispredict_target_i,
  input  logic             fetch_done_i,
  input  logic             pred_taken_i,
  input  fetch_pkg::addr_t pred_target_i,
  output fetch_pkg::addr_t pc_o,
  output logic             redirect_o
);

  // set during reset, cleared after the first clock edge
  logic rst_load_q;

  fetch_pkg::addr_t pc_q;
  fetch_pkg::addr_t pc_d;
  fetch_pkg::addr_t cur_pc;

  // boot address is used until the register holds it
  assign cur_pc = rst_load_q ? boot_addr_i : pc_q;
  assign pc_o   = cur_pc;

  // any backend event flushes the frontend
  assign redirect_o = ex_valid_i | eret_i | mispredict_i;

  // ------------------------------------------------------------
  // next pc selection
  // ------------------------------------------------------------
  always_comb begin
    // hold by default, this also loads the boot address
    pc_d = cur_pc;
    if (ex_valid_i) begin
      pc_d = trap_vector_i;
    end else if (eret_i) begin
      pc_d = epc_i;
    end else if (mispredict_i) begin
      pc_d = mispredict_target_i;
    end else if (fetch_done_i) begin
      // the held pc is still the address of the returned word
      if (pred_taken_i) begin
        pc_d = pred_target_i;
      end else begin
        pc_d = cur_pc + fetch_pkg::InstrBytes;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rst_load_q <= 1'b1;
      pc_q       <= '0;
    end else begin
      rst_load_q <= 1'b0;
      pc_q       <= pc_d;
    end
  end

endmodule

//--- src/fetch_mem_port.sv
// four-phase req/ack master toward instruction memory
// one request at a time, a new one starts only after ack is seen low
// a redirect during an open handshake drops its word but lets it finish

`timescale 1ns/1ps

module fetch_mem_port (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  fetch_pkg::addr_t  pc_i,
  input  logic              redirect_i,
  input  logic              queue_full_i,
  input  logic              mem_ack_i,
  input  fetch_pkg::instr_t mem_rdata_i,
  output logic              mem_req_o,
  output fetch_pkg::addr_t  mem_addr_o,
  output logic              fetch_done_o,
  output fetch_pkg::addr_t  fetch_addr_o,
  output fetch_pkg::instr_t fetch_word_o
);

  typedef enum logic [1:0] {
    IDLE,
    WAIT_ACK,
    WAIT_RELEASE
  } state_e;

  state_e state_q, state_d;

  // marks the open handshake as stale
  logic kill_q, kill_d;
  logic done_q, done_d;

  fetch_pkg::addr_t  addr_q;
  fetch_pkg::instr_t word_q;

  // the request stays up until the ack has been sampled
  assign mem_req_o    = (state_q == WAIT_ACK);
  assign mem_addr_o   = addr_q;
  // address is held until the next request starts
  assign fetch_addr_o = addr_q;
  assign fetch_word_o = word_q;
  assign fetch_done_o = done_q;

  // ------------------------------------------------------------
  // handshake fsm
  // ------------------------------------------------------------
  always_comb begin
    state_d = state_q;
    kill_d  = kill_q;
    done_d  = 1'b0;
    unique case (state_q)
      IDLE: begin
        // no start while the pc is about to change or the queue has no room
        if (!queue_full_i && !redirect_i) begin
          state_d = WAIT_ACK;
          kill_d  = 1'b0;
        end
      end
      WAIT_ACK: begin
        if (redirect_i) begin
          kill_d = 1'b1;
        end
        if (mem_ack_i) begin
          // a redirect in the ack cycle kills the word as well
          done_d  = !kill_q && !redirect_i;
          state_d = WAIT_RELEASE;
        end
      end
      WAIT_RELEASE: begin
        // memory has to drop ack before the next phase one
        if (!mem_ack_i) begin
          state_d = IDLE;
          kill_d  = 1'b0;
        end
      end
      default: begin
        state_d = IDLE;
        kill_d  = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      kill_q  <= 1'b0;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      kill_q  <= kill_d;
      done_q  <= done_d;
    end
  end

  // address and word registers
  always_ff @(posedge clk_i) begin
    if (state_q == IDLE && state_d == WAIT_ACK) begin
      addr_q <= pc_i;
    end
    if (state_q == WAIT_ACK && mem_ack_i) begin
      word_q <= mem_rdata_i;
    end
  end

endmodule

//--- src/instr_predecode.sv
// control-flow predecode and static prediction for one word
// only the 32-bit encodings of branch, jal and jalr are recognized
// jalr is reported but never predicted, its target reads as zero

`timescale 1ns/1ps

module instr_predecode (
  input  fetch_pkg::addr_t  pc_i,
  input  fetch_pkg::instr_t instr_i,
  output fetch_pkg::cf_t    cf_o,
  output logic              taken_o,
  output fetch_pkg::addr_t  target_o
);

  // major opcodes of the control-flow instructions
  localparam logic [6:0] OpBranch = 7'b1100011;
  localparam logic [6:0] OpJal    = 7'b1101111;
  localparam logic [6:0] OpJalr   = 7'b1100111;

  logic [6:0] opcode;

  fetch_pkg::addr_t b_imm;
  fetch_pkg::addr_t j_imm;

  assign opcode = instr_i[6:0];

  // ------------------------------------------------------------
  // immediates, sign-extended to the address width
  // ------------------------------------------------------------

  // B-type, bit 0 is implied zero
  assign b_imm = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};

  // J-type, bit 0 is implied zero
  assign j_imm = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

  // ------------------------------------------------------------
  // classification and prediction
  // ------------------------------------------------------------
  always_comb begin
    cf_o     = fetch_pkg::CF_NONE;
    taken_o  = 1'b0;
    target_o = '0;
    unique case (opcode)
      OpBranch: begin
        cf_o     = fetch_pkg::CF_BRANCH;
        // backward branches are assumed to close a loop
        taken_o  = b_imm[fetch_pkg::AddrWidth-1];
        target_o = pc_i + b_imm;
      end
      OpJal: begin
        cf_o     = fetch_pkg::CF_JUMP;
        taken_o  = 1'b1;
        target_o = pc_i + j_imm;
      end
      OpJalr: begin
        // register target, fetch just goes on sequentially
        cf_o = fetch_pkg::CF_JUMPR;
      end
      default: begin
        cf_o = fetch_pkg::CF_NONE;
      end
    endcase
  end

endmodule

//--- src/fetch_queue.sv
// circular FIFO of fetch entries toward decode
// an entry pushed into an empty queue is visible in the same cycle
// flush wins over push and pop, QueueDepth must be 2 or more

`timescale 1ns/1ps

module fetch_queue #(
  parameter int unsigned QueueDepth = 4
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              flush_i,
  input  logic              push_i,
  input  fetch_pkg::addr_t  pc_i,
  input  fetch_pkg::instr_t instr_i,
  input  fetch_pkg::cf_t    cf_i,
  input  logic              taken_i,
  input  fetch_pkg::addr_t  target_i,
  input  logic              ready_i,
  output logic              full_o,
  output logic              valid_o,
  output fetch_pkg::addr_t  pc_o,
  output fetch_pkg::instr_t instr_o,
  output fetch_pkg::cf_t    cf_o,
  output logic              taken_o,
  output fetch_pkg::addr_t  target_o
);

  localparam int unsigned PtrWidth = $clog2(QueueDepth);
  localparam int unsigned CntWidth = $clog2(QueueDepth + 1);

  logic [PtrWidth-1:0] rd_ptr_q, wr_ptr_q;
  logic [CntWidth-1:0] count_q;

  logic empty;
  logic pop_mem;
  logic write;

  // entry storage
  fetch_pkg::addr_t  pc_mem_q     [QueueDepth];
  fetch_pkg::instr_t instr_mem_q  [QueueDepth];
  fetch_pkg::cf_t    cf_mem_q     [QueueDepth];
  logic              taken_mem_q  [QueueDepth];
  fetch_pkg::addr_t  target_mem_q [QueueDepth];

  // pointer step with wrap for any depth
  function automatic logic [PtrWidth-1:0] ptr_inc(input logic [PtrWidth-1:0] ptr);
    if (ptr == PtrWidth'(QueueDepth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign empty  = (count_q == '0);
  assign full_o = (count_q == CntWidth'(QueueDepth));

  // ------------------------------------------------------------
  // output side
  // ------------------------------------------------------------

  // empty queue passes the incoming entry straight through
  assign valid_o  = !flush_i && (!empty || push_i);
  assign pc_o     = empty ? pc_i     : pc_mem_q[rd_ptr_q];
  assign instr_o  = empty ? instr_i  : instr_mem_q[rd_ptr_q];
  assign cf_o     = empty ? cf_i     : cf_mem_q[rd_ptr_q];
  assign taken_o  = empty ? taken_i  : taken_mem_q[rd_ptr_q];
  assign target_o = empty ? target_i : target_mem_q[rd_ptr_q];

  // pop of a stored entry
  assign pop_mem = !flush_i && !empty && ready_i;

  // store unless the pass-through entry was taken right away
  assign write = !flush_i && push_i && !(empty && ready_i) && (!full_o || pop_mem);

  // ------------------------------------------------------------
  // pointers and count
  // ------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (write) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop_mem) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      // simultaneous write and pop leave the count unchanged
      if (write && !pop_mem) begin
        count_q <= count_q + 1'b1;
      end else if (!write && pop_mem) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (write) begin
      pc_mem_q[wr_ptr_q]     <= pc_i;
      instr_mem_q[wr_ptr_q]  <= instr_i;
      cf_mem_q[wr_ptr_q]     <= cf_i;
      taken_mem_q[wr_ptr_q]  <= taken_i;
      target_mem_q[wr_ptr_q] <= target_i;
    end
  end

endmodule

//--- src/fetch_frontend.sv
// single-issue fetch frontend with static prediction
// memory side is a four-phase req/ack, one word in flight at most
// decode side transfers on valid and ready both high

`timescale 1ns/1ps

module fetch_frontend #(
  parameter int unsigned QueueDepth = 4
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  fetch_pkg::addr_t  boot_addr_i,
  // backend redirects
  input  logic              ex_valid_i,
  input  fetch_pkg::addr_t  trap_vector_i,
  input  logic              eret_i,
  input  fetch_pkg::addr_t  epc_i,
  input  logic              mispredict_i,
  input  fetch_pkg::addr_t  mispredict_target_i,
  // instruction memory
  output logic              mem_req_o,
  output fetch_pkg::addr_t  mem_addr_o,
  input  logic              mem_ack_i,
  input  fetch_pkg::instr_t mem_rdata_i,
  // decode
  output logic              fetch_valid_o,
  input  logic              fetch_ready_i,
  output fetch_pkg::addr_t  fetch_pc_o,
  output fetch_pkg::instr_t fetch_instr_o,
  output fetch_pkg::cf_t    fetch_cf_o,
  output logic              fetch_taken_o,
  output fetch_pkg::addr_t  fetch_target_o
);

  fetch_pkg::addr_t  pc;
  logic              redirect;
  logic              queue_full;
  logic              fetch_done;
  fetch_pkg::addr_t  fetch_addr;
  fetch_pkg::instr_t fetch_word;
  fetch_pkg::cf_t    pred_cf;
  logic              pred_taken;
  fetch_pkg::addr_t  pred_target;

  fetch_pc_gen u_pc_gen (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .boot_addr_i         (boot_addr_i),
    .ex_valid_i          (ex_valid_i),
    .trap_vector_i       (trap_vector_i),
    .eret_i              (eret_i),
    .epc_i               (epc_i),
    .mispredict_i        (mispredict_i),
    .mispredict_target_i (mispredict_target_i),
    .fetch_done_i        (fetch_done),
    .pred_taken_i        (pred_taken),
    .pred_target_i       (pred_target),
    .pc_o                (pc),
    .redirect_o          (redirect)
  );

  fetch_mem_port u_mem_port (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .pc_i         (pc),
    .redirect_i   (redirect),
    .queue_full_i (queue_full),
    .mem_ack_i    (mem_ack_i),
    .mem_rdata_i  (mem_rdata_i),
    .mem_req_o    (mem_req_o),
    .mem_addr_o   (mem_addr_o),
    .fetch_done_o (fetch_done),
    .fetch_addr_o (fetch_addr),
    .fetch_word_o (fetch_word)
  );

  // prediction feeds both the queue entry and the next pc
  instr_predecode u_predecode (
    .pc_i     (fetch_addr),
    .instr_i  (fetch_word),
    .cf_o     (pred_cf),
    .taken_o  (pred_taken),
    .target_o (pred_target)
  );

  fetch_queue #(
    .QueueDepth (QueueDepth)
  ) u_queue (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .flush_i  (redirect),
    .push_i   (fetch_done),
    .pc_i     (fetch_addr),
    .instr_i  (fetch_word),
    .cf_i     (pred_cf),
    .taken_i  (pred_taken),
    .target_i (pred_target),
    .ready_i  (fetch_ready_i),
    .full_o   (queue_full),
    .valid_o  (fetch_valid_o),
    .pc_o     (fetch_pc_o),
    .instr_o  (fetch_instr_o),
    .cf_o     (fetch_cf_o),
    .taken_o  (fetch_taken_o),
    .target_o (fetch_target_o)
  );

endmodule

//--- bench/tb_fetch_frontend.sv
// self-checking testbench for the fetch frontend
// the program image spans 0x1000 to 0x1fff and every fetch has to stay inside it
// the run stops at the first mismatch or timeout

`timescale 1ns/1ps

module tb_fetch_frontend;

  localparam int unsigned      QueueDepth   = 4;
  localparam int unsigned      ImageWords   = 1024;
  localparam int unsigned      WaitLimit    = 500;
  localparam int unsigned      MemIdleLimit = 2000;
  localparam fetch_pkg::addr_t ImageBase    = 32'h0000_1000;
  localparam fetch_pkg::addr_t BootAddr     = 32'h0000_1000;
  localparam fetch_pkg::addr_t LoopAddr     = 32'h0000_1050;
  localparam fetch_pkg::addr_t TrapBase     = 32'h0000_1800;
  localparam fetch_pkg::addr_t EpcBase      = 32'h0000_1400;
  localparam fetch_pkg::addr_t MispBase     = 32'h0000_1200;

  logic              clk_i = 1'b0;
  logic              rst_ni;
  fetch_pkg::addr_t  boot_addr_i;
  logic              ex_valid_i;
  fetch_pkg::addr_t  trap_vector_i;
  logic              eret_i;
  fetch_pkg::addr_t  epc_i;
  logic              mispredict_i;
  fetch_pkg::addr_t  mispredict_target_i;
  logic              mem_req_o;
  fetch_pkg::addr_t  mem_addr_o;
  logic              mem_ack_i;
  fetch_pkg::instr_t mem_rdata_i;
  logic              fetch_valid_o;
  logic              fetch_ready_i;
  fetch_pkg::addr_t  fetch_pc_o;
  fetch_pkg::instr_t fetch_instr_o;
  fetch_pkg::cf_t    fetch_cf_o;
  logic              fetch_taken_o;
  fetch_pkg::addr_t  fetch_target_o;

  fetch_pkg::instr_t image [ImageWords];
  int unsigned       seed = 32'h6659_4513;

  // state of the compare process
  fetch_pkg::addr_t  exp_pc = BootAddr;
  fetch_pkg::addr_t  next_pc;
  fetch_pkg::addr_t  ref_target;
  fetch_pkg::cf_t    ref_cf;
  logic              ref_taken;
  fetch_pkg::instr_t ref_word;
  int unsigned       xfer_count = 0;
  int                pending = 0;
  int                pending_start = 0;
  logic              req_seen = 1'b0;
  logic              ack_seen = 1'b0;
  logic              hs_killed = 1'b0;
  logic              hold_valid = 1'b0;
  fetch_pkg::addr_t  hold_pc;
  fetch_pkg::instr_t hold_instr;
  logic              redirect;
  logic              push_now;
  logic              xfer;

  fetch_frontend #(
    .QueueDepth (QueueDepth)
  ) u_dut (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .boot_addr_i         (boot_addr_i),
    .ex_valid_i          (ex_valid_i),
    .trap_vector_i       (trap_vector_i),
    .eret_i              (eret_i),
    .epc_i               (epc_i),
    .mispredict_i        (mispredict_i),
    .mispredict_target_i (mispredict_target_i),
    .mem_req_o           (mem_req_o),
    .mem_addr_o          (mem_addr_o),
    .mem_ack_i           (mem_ack_i),
    .mem_rdata_i         (mem_rdata_i),
    .fetch_valid_o       (fetch_valid_o),
    .fetch_ready_i       (fetch_ready_i),
    .fetch_pc_o          (fetch_pc_o),
    .fetch_instr_o       (fetch_instr_o),
    .fetch_cf_o          (fetch_cf_o),
    .fetch_taken_o       (fetch_taken_o),
    .fetch_target_o      (fetch_target_o)
  );

  always #5 clk_i = ~clk_i;

  // ------------------------------------------------------------
  // reporting
  // ------------------------------------------------------------
  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("CHECKS FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      fail_run($sformatf("FAILED %s: got 0x%08h, expected 0x%08h", name, actual, expected));
    end
  endtask

  // ------------------------------------------------------------
  // program image
  // ------------------------------------------------------------

  // beq x1, x2 with the given byte offset
  function automatic fetch_pkg::instr_t encode_branch(input fetch_pkg::addr_t off);
    return {off[12], off[10:5], 5'd2, 5'd1, 3'b000, off[4:1], off[11], 7'b1100011};
  endfunction

  // jal x1 with the given byte offset
  function automatic fetch_pkg::instr_t encode_jal(input fetch_pkg::addr_t off);
    return {off[20], off[10:1], off[11], off[19:12], 5'd1, 7'b1101111};
  endfunction

  // jalr x0, 0(x1)
  function automatic fetch_pkg::instr_t encode_jalr();
    return {12'd0, 5'd1, 3'b000, 5'd0, 7'b1100111};
  endfunction

  function automatic logic in_image(input fetch_pkg::addr_t addr);
    return (addr >= ImageBase) && (addr < ImageBase + 4 * ImageWords) && (addr[1:0] == 2'b00);
  endfunction

  function automatic fetch_pkg::instr_t image_word(input fetch_pkg::addr_t addr);
    return image[(addr - ImageBase) >> 2];
  endfunction

  task automatic place(input fetch_pkg::addr_t addr, input fetch_pkg::instr_t word);
    image[(addr - ImageBase) >> 2] = word;
  endtask

  task automatic build_image();
    fetch_pkg::instr_t w;
    // random filler where any control-flow opcode is turned into op-imm
    for (int i = 0; i < ImageWords; i++) begin
      w = $urandom;
      if (w[6:0] == 7'b1100011 || w[6:0] == 7'b1101111 || w[6:0] == 7'b1100111) begin
        w[6:0] = 7'b0010011;
      end
      image[i] = w;
    end
    // straight line from boot followed by a forward branch, jal and jalr
    place(32'h1020, encode_branch(32'h10));
    place(32'h102c, encode_jal(32'h104c - 32'h102c));
    place(32'h104c, encode_jalr());
    // main loop closed by a backward branch
    place(32'h1058, encode_branch(32'h1068 - 32'h1058));
    place(32'h1060, encode_jal(32'h1068 - 32'h1060));
    place(32'h106c, encode_branch(LoopAddr - 32'h106c));
    // redirect targets run a few words and jump back into the loop
    place(TrapBase + 32'h10, encode_jal(LoopAddr - (TrapBase + 32'h10)));
    place(EpcBase + 32'h10, encode_jal(LoopAddr - (EpcBase + 32'h10)));
    place(MispBase + 32'h10, encode_jal(LoopAddr - (MispBase + 32'h10)));
  endtask

  // ------------------------------------------------------------
  // reference model of the static prediction
  // ------------------------------------------------------------
  function automatic fetch_pkg::addr_t ref_next_pc(
    input  fetch_pkg::addr_t  pc,
    input  fetch_pkg::instr_t word,
    output fetch_pkg::cf_t    cf,
    output logic              taken,
    output fetch_pkg::addr_t  target
  );
    logic [12:0] b_off;
    logic [20:0] j_off;
    cf     = fetch_pkg::CF_NONE;
    taken  = 1'b0;
    target = '0;
    b_off  = {word[31], word[7], word[30:25], word[11:8], 1'b0};
    j_off  = {word[31], word[19:12], word[20], word[30:21], 1'b0};
    case (word[6:0])
      7'b1100011: begin
        cf     = fetch_pkg::CF_BRANCH;
        target = pc + {{19{b_off[12]}}, b_off};
        // negative offset means predicted taken
        taken  = b_off[12];
      end
      7'b1101111: begin
        cf     = fetch_pkg::CF_JUMP;
        target = pc + {{11{j_off[20]}}, j_off};
        taken  = 1'b1;
      end
      7'b1100111: begin
        cf = fetch_pkg::CF_JUMPR;
      end
      default: begin
        cf = fetch_pkg::CF_NONE;
      end
    endcase
    if (taken) begin
      return target;
    end
    return pc + 32'd4;
  endfunction

  // ------------------------------------------------------------
  // four-phase instruction memory with 0 to 3 cycles of ack delay
  // ------------------------------------------------------------
  initial begin : memory_model
    int unsigned idle;
    int unsigned delay;
    forever begin
      idle = 0;
      @(negedge clk_i);
      while (!mem_req_o) begin
        idle++;
        if (idle > MemIdleLimit) begin
          fail_run("no memory request arrived within the idle limit");
        end
        @(negedge clk_i);
      end
      delay = $urandom_range(0, 3);
      repeat (delay) @(posedge clk_i);
      @(posedge clk_i);
      #1;
      if (!in_image(mem_addr_o)) begin
        fail_run($sformatf("memory request at 0x%08h lies outside the program image",
                           mem_addr_o));
      end
      mem_ack_i   = 1'b1;
      mem_rdata_i = image_word(mem_addr_o);
      idle = 0;
      @(negedge clk_i);
      while (mem_req_o) begin
        idle++;
        if (idle > WaitLimit) begin
          fail_run("request was not dropped after the ack");
        end
        @(negedge clk_i);
      end
      @(posedge clk_i);
      #1;
      mem_ack_i   = 1'b0;
      mem_rdata_i = '0;
    end
  end

  // ------------------------------------------------------------
  // compare process sampling mid-cycle on the falling edge
  // ------------------------------------------------------------
  always @(negedge clk_i) begin
    if (rst_ni) begin
      redirect = ex_valid_i | eret_i | mispredict_i;
      // a new request needs room left in the queue the cycle before
      if (mem_req_o && !req_seen) begin
        check_value("mem_req_o", 32'd1, 32'(pending_start < int'(QueueDepth)));
        hs_killed = 1'b0;
      end
      if (redirect && mem_req_o) begin
        hs_killed = 1'b1;
      end
      pending_start = pending;
      // entry lands in the queue the cycle after the ack
      push_now = ack_seen && !hs_killed;
      xfer     = fetch_valid_o && fetch_ready_i;
      // a flush hides the queue in the same cycle
      if (redirect) begin
        check_value("fetch_valid_o", 32'(fetch_valid_o), 32'd0);
      end else if (push_now) begin
        check_value("fetch_valid_o", 32'(fetch_valid_o), 32'd1);
      end
      // stalled entry has to stay put
      if (hold_valid && fetch_valid_o && !redirect) begin
        check_value("fetch_pc_o", fetch_pc_o, hold_pc);
        check_value("fetch_instr_o", fetch_instr_o, hold_instr);
      end
      if (xfer) begin
        ref_word = image_word(exp_pc);
        next_pc  = ref_next_pc(exp_pc, ref_word, ref_cf, ref_taken, ref_target);
        check_value("fetch_pc_o", fetch_pc_o, exp_pc);
        check_value("fetch_instr_o", fetch_instr_o, ref_word);
        check_value("fetch_cf_o", 32'(fetch_cf_o), 32'(ref_cf));
        check_value("fetch_taken_o", 32'(fetch_taken_o), 32'(ref_taken));
        check_value("fetch_target_o", fetch_target_o, ref_target);
        exp_pc = next_pc;
        xfer_count++;
      end
      hold_valid = fetch_valid_o && !fetch_ready_i;
      hold_pc    = fetch_pc_o;
      hold_instr = fetch_instr_o;
      if (redirect) begin
        pending    = 0;
        hold_valid = 1'b0;
        // exception > eret > mispredict
        if (ex_valid_i) begin
          exp_pc = trap_vector_i;
        end else if (eret_i) begin
          exp_pc = epc_i;
        end else begin
          exp_pc = mispredict_target_i;
        end
      end else begin
        pending = pending + int'(push_now) - int'(xfer);
      end
      ack_seen = mem_ack_i && mem_req_o;
      req_seen = mem_req_o;
    end
  end

  // ------------------------------------------------------------
  // stimulus helpers are called and return 1 ns after an edge
  // ------------------------------------------------------------
  task automatic wait_transfers(input int unsigned count);
    int unsigned target;
    int unsigned cycles;
    target = xfer_count + count;
    cycles = 0;
    while (xfer_count < target) begin
      @(posedge clk_i);
      #1;
      cycles++;
      if (cycles > WaitLimit) begin
        fail_run("timed out waiting for decode transfers");
      end
    end
  endtask

  task automatic wait_queue_full();
    int unsigned cycles;
    cycles = 0;
    while (pending != int'(QueueDepth)) begin
      @(posedge clk_i);
      #1;
      cycles++;
      if (cycles > WaitLimit) begin
        fail_run("timed out waiting for the queue to fill");
      end
    end
  endtask

  task automatic wait_open_request();
    int unsigned cycles;
    cycles = 0;
    while (!mem_req_o) begin
      @(posedge clk_i);
      #1;
      cycles++;
      if (cycles > WaitLimit) begin
        fail_run("timed out waiting for a memory request");
      end
    end
  endtask

  // one-cycle backend event with targets inside the redirect regions
  task automatic pulse_redirect(input logic ex, input logic er, input logic mp);
    trap_vector_i       = TrapBase + 4 * $urandom_range(0, 3);
    epc_i               = EpcBase + 4 * $urandom_range(0, 3);
    mispredict_target_i = MispBase + 4 * $urandom_range(0, 3);
    ex_valid_i          = ex;
    eret_i              = er;
    mispredict_i        = mp;
    @(posedge clk_i);
    #1;
    ex_valid_i   = 1'b0;
    eret_i       = 1'b0;
    mispredict_i = 1'b0;
  endtask

  task automatic redirect_with_full_queue(input logic ex, input logic er, input logic mp);
    fetch_ready_i = 1'b0;
    wait_queue_full();
    pulse_redirect(ex, er, mp);
    fetch_ready_i = 1'b1;
    wait_transfers(6);
  endtask

  // ------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------
  initial begin
    void'($urandom(seed));
    rst_ni              = 1'b0;
    boot_addr_i         = BootAddr;
    ex_valid_i          = 1'b0;
    trap_vector_i       = TrapBase;
    eret_i              = 1'b0;
    epc_i               = EpcBase;
    mispredict_i        = 1'b0;
    mispredict_target_i = MispBase;
    mem_ack_i           = 1'b0;
    mem_rdata_i         = '0;
    fetch_ready_i       = 1'b0;
    build_image();
    repeat (5) @(posedge clk_i);
    #1;
    check_value("mem_req_o", 32'(mem_req_o), 32'd0);
    check_value("fetch_valid_o", 32'(fetch_valid_o), 32'd0);
    rst_ni        = 1'b1;
    fetch_ready_i = 1'b1;

    // first request one cycle after release carries the boot address
    @(posedge clk_i);
    #1;
    check_value("mem_req_o", 32'(mem_req_o), 32'd1);
    check_value("mem_addr_o", mem_addr_o, BootAddr);

    // boot and straight line code, branches, jal, jalr and a few loop turns
    wait_transfers(40);

    // back-pressure until full and beyond
    for (int i = 0; i < 8; i++) begin
      fetch_ready_i = 1'b0;
      wait_queue_full();
      repeat ($urandom_range(3, 12)) @(posedge clk_i);
      #1;
      fetch_ready_i = 1'b1;
      repeat ($urandom_range(1, 8)) @(posedge clk_i);
      #1;
    end
    wait_transfers(4);

    // single and combined redirects while a handshake is open
    wait_open_request();
    pulse_redirect(1'b1, 1'b0, 1'b0);
    wait_transfers(6);
    wait_open_request();
    pulse_redirect(1'b0, 1'b1, 1'b0);
    wait_transfers(6);
    wait_open_request();
    pulse_redirect(1'b0, 1'b0, 1'b1);
    wait_transfers(6);
    wait_open_request();
    pulse_redirect(1'b1, 1'b0, 1'b1);
    wait_transfers(6);
    wait_open_request();
    pulse_redirect(1'b0, 1'b1, 1'b1);
    wait_transfers(6);
    wait_open_request();
    pulse_redirect(1'b1, 1'b1, 1'b1);
    wait_transfers(6);

    // redirects into a full queue
    redirect_with_full_queue(1'b1, 1'b0, 1'b0);
    redirect_with_full_queue(1'b0, 1'b1, 1'b0);
    redirect_with_full_queue(1'b0, 1'b0, 1'b1);
    redirect_with_full_queue(1'b0, 1'b1, 1'b1);

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

//--- fetch_frontend.f
src/fetch_pkg.sv
src/fetch_pc_gen.sv
src/fetch_mem_port.sv
src/instr_predecode.sv
src/fetch_queue.sv
src/fetch_frontend.sv
bench/tb_fetch_frontend.sv

//--- Bender.yml
package:
  name: fetch_frontend

sources:
  # package first, then the leaf modules and the top level
  - src/fetch_pkg.sv
  - src/fetch_pc_gen.sv
  - src/fetch_mem_port.sv
  - src/instr_predecode.sv
  - src/fetch_queue.sv
  - src/fetch_frontend.sv
  - target: test
    files:
      - bench/tb_fetch_frontend.sv
